//--- build.f
hdl/mcu_cmd_pkg.sv
hdl/cmd_config_regs.sv
hdl/addr_pointers.sv
hdl/mcu_mem_req.sv
hdl/spi_response.sv
hdl/dspx_loader.sv
hdl/mcu_cmd_top.sv
dv/mcu_cmd_properties.sv
dv/tb_mcu_cmd.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the MCU command decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mcu_cmd -f build.f

out=$(./obj_dir/Vtb_mcu_cmd 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

//--- dv/tb_mcu_cmd.sv
module tb_mcu_cmd;

  localparam logic [7:0] id_byte = 8'ha5;
  localparam int num_txn = 26;
  localparam int timeout_cycles = num_txn * 7 * 12 + 100;

  // one transaction, parameters in send order
  typedef struct packed {
    logic [7:0]      cmd;
    logic [2:0]      n;
    logic [0:5][7:0] p;
    logic [23:0]     exp;
  } txn_t;

  logic                  clk;
  logic                  rst;
  mcu_cmd_pkg::spi_cmd_t spi;
  logic                  mcu_rq_rdy;
  logic [7:0]            mcu_data_in;
  logic                  mcu_rrq;
  logic                  mcu_wrq;
  logic [7:0]            mcu_data_out;
  logic                  dac_status;
  logic [6:0]            msu_status;
  logic [7:0]            spi_data_out;
  mcu_cmd_pkg::cfg_t     cfg;
  mcu_cmd_pkg::ptr_t     ptr;
  mcu_cmd_pkg::dspx_t    dspx;

  integer      seed = 32'he02f_49b9;
  int          errors = 0;
  int          checks = 0;
  int          resp_cnt = 0;
  int          rrq_cnt = 0;
  int          wrq_cnt = 0;
  int          exp_rrq = 0;
  int          exp_wrq = 0;
  logic        pgm_we_q = 1'b0;
  logic        dat_we_q = 1'b0;
  logic [34:0] pgm_log[$];
  logic [25:0] dat_log[$];
  logic [23:0] exp_addr = '0;
  logic [10:0] exp_pgm_addr = '0;
  logic [9:0]  exp_dat_addr = '0;

  // cmd, param count, params, expected value after the transaction
  txn_t tbl [num_txn] = '{
    {8'h35, 3'd0, 48'h0000_0000_0000, 24'h000005},
    {8'h10, 3'd3, 48'h3fff_ff00_0000, 24'h3fffff},
    {8'h20, 3'd3, 48'h001f_ff00_0000, 24'h001fff},
    {8'hec, 3'd1, 48'h8500_0000_0000, 24'h00000d},
    {8'hed, 3'd1, 48'ha700_0000_0000, 24'h0000a7},
    {8'hee, 3'd1, 48'h0100_0000_0000, 24'h000001},
    {8'h00, 3'd3, 48'h1234_5600_0000, 24'h123456},
    {8'h00, 3'd1, 48'hab00_0000_0000, 24'hab0000},
    {8'h01, 3'd2, 48'h0567_0000_0000, 24'h000567},
    {8'h01, 3'd1, 48'h0700_0000_0000, 24'h000700},
    {8'h02, 3'd2, 48'h2abc_0000_0000, 24'h002abc},
    {8'h02, 3'd1, 48'h3f00_0000_0000, 24'h003f00},
    {8'h00, 3'd3, 48'h0010_fe00_0000, 24'h0010fe},
    {8'h88, 3'd3, 48'h0000_0000_0000, 24'h001102},
    {8'h98, 3'd3, 48'h1122_3300_0000, 24'h001105},
    {8'h90, 3'd1, 48'h4400_0000_0000, 24'h001105},
    {8'hf0, 3'd2, 48'h0000_0000_0000, 24'h0000a5},
    {8'hff, 3'd3, 48'h3cc3_9600_0000, 24'h000096},
    {8'hf1, 3'd2, 48'h0000_0000_0000, 24'h000060},
    {8'he8, 3'd1, 48'h0000_0000_0000, 24'h000000},
    {8'he9, 3'd5, 48'h1234_5600_0000, 24'h000001},
    {8'he9, 3'd5, 48'habcd_ef00_0000, 24'h000002},
    {8'hea, 3'd4, 48'hbeef_0000_0000, 24'h000001},
    {8'heb, 3'd1, 48'h0000_0000_0000, 24'h000000},
    {8'heb, 3'd1, 48'h0100_0000_0000, 24'h000001},
    {8'he8, 3'd1, 48'h0000_0000_0000, 24'h000000}
  };

  mcu_cmd_top #(
    .id_byte (id_byte)
  ) u_mcu_cmd_top (
    .clk          (clk),
    .rst          (rst),
    .spi          (spi),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .dac_status   (dac_status),
    .msu_status   (msu_status),
    .spi_data_out (spi_data_out),
    .cfg          (cfg),
    .ptr          (ptr),
    .dspx         (dspx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: transactions still running after %0d cycles", cycles);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////
  // memory model
  ////////////////////

  initial begin : mem_model
    int         delay;
    logic [7:0] addr_lo;
    mcu_rq_rdy = 1'b0;
    mcu_data_in = 8'h00;
    forever begin
      @(negedge clk);
      if (mcu_rrq || mcu_wrq) begin
        delay = 2 + int'($unsigned($random(seed)) % 5);
        addr_lo = ptr.addr[7:0];
        @(posedge clk);
        mcu_rq_rdy <= 1'b0;
        repeat (delay - 1) @(posedge clk);
        mcu_rq_rdy <= 1'b1;
        mcu_data_in <= addr_lo ^ 8'h5a;
        resp_cnt++;
      end
    end
  end

  // request counts and dsp write pulses
  always @(negedge clk) begin
    if (mcu_rrq) rrq_cnt++;
    if (mcu_wrq) wrq_cnt++;
    if (dspx.pgm_we && !pgm_we_q) pgm_log.push_back({dspx.pgm_addr, dspx.pgm_data});
    if (dspx.dat_we && !dat_we_q) dat_log.push_back({dspx.dat_addr, dspx.dat_data});
    pgm_we_q = dspx.pgm_we;
    dat_we_q = dspx.dat_we;
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [63:0] observed_value(input logic [7:0] cmd);
    logic [63:0] v;
    case (cmd[7:4])
      mcu_cmd_pkg::grp_addr: begin
        case (cmd[1:0])
          2'b01: v = 64'(ptr.dac_addr);
          2'b10: v = 64'(ptr.msu_addr);
          default: v = 64'(ptr.addr);
        endcase
      end
      mcu_cmd_pkg::grp_rom_mask: v = 64'(cfg.rom_mask);
      mcu_cmd_pkg::grp_sram_mask: v = 64'(cfg.sram_mask);
      mcu_cmd_pkg::grp_mapper: v = 64'(cfg.mapper);
      mcu_cmd_pkg::grp_read, mcu_cmd_pkg::grp_write: v = 64'(ptr.addr);
      4'he: begin
        case (cmd)
          mcu_cmd_pkg::op_dac_props: v = 64'({cfg.dac_pal, cfg.dac_vol});
          mcu_cmd_pkg::op_features: v = 64'(cfg.features);
          mcu_cmd_pkg::op_region: v = 64'(cfg.region);
          mcu_cmd_pkg::op_dspx_rst_addr: v = 64'({dspx.pgm_addr, dspx.dat_addr});
          mcu_cmd_pkg::op_dspx_pgm: v = 64'(dspx.pgm_addr);
          mcu_cmd_pkg::op_dspx_dat: v = 64'(dspx.dat_addr);
          default: v = 64'(dspx.reset);
        endcase
      end
      default: v = 64'(spi_data_out);
    endcase
    return v;
  endfunction

  // one byte strobe after an idle gap, returns where outputs are stable
  task automatic send_strobe(input logic is_cmd, input logic [7:0] cmd,
                             input logic [7:0] param, input logic [7:0] cnt);
    repeat (2) @(posedge clk);
    spi.cmd_ready <= is_cmd;
    spi.param_ready <= ~is_cmd;
    spi.cmd.op <= cmd;
    spi.param <= param;
    spi.byte_cnt <= cnt;
    @(posedge clk);
    spi.cmd_ready <= 1'b0;
    spi.param_ready <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_mem_response(input int target);
    while (resp_cnt < target) begin
      @(negedge clk);
    end
    // response byte lands two edges after the ready rise
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic run_txn(input txn_t t);
    int          b;
    logic [7:0]  param;
    logic [7:0]  cnt;
    logic [3:0]  grp;
    logic [7:0]  exp_byte;
    logic [34:0] pgm_word;
    logic [25:0] dat_word;
    grp = t.cmd[7:4];
    for (b = 0; b <= int'(t.n); b++) begin
      cnt = 8'(b + 1);
      param = (b == 0) ? 8'h00 : t.p[b-1];
      send_strobe(b == 0, t.cmd, param, cnt);
      if (grp == mcu_cmd_pkg::grp_read || (grp == mcu_cmd_pkg::grp_write && b > 0)) begin
        if (grp == mcu_cmd_pkg::grp_read) exp_rrq++;
        else exp_wrq++;
        wait_mem_response(exp_rrq + exp_wrq);
        check_value("read requests", 64'(rrq_cnt), 64'(exp_rrq));
        check_value("write requests", 64'(wrq_cnt), 64'(exp_wrq));
        if (grp == mcu_cmd_pkg::grp_read) begin
          check_value("read byte", 64'(spi_data_out), 64'(exp_addr[7:0] ^ 8'h5a));
        end else begin
          check_value("write data", 64'(mcu_data_out), 64'(param));
        end
        // step on bit 3 once past the address bytes
        if (t.cmd[3] && cnt >= 8'(1 + int'(t.cmd[4]))) exp_addr = exp_addr + 24'd1;
        check_value("main address", 64'(ptr.addr), 64'(exp_addr));
      end else if (t.cmd == mcu_cmd_pkg::op_id) begin
        check_value("id byte", 64'(spi_data_out), 64'(id_byte));
      end else if (t.cmd == mcu_cmd_pkg::op_echo && b > 0) begin
        check_value("echo byte", 64'(spi_data_out), 64'(param));
      end else if (t.cmd == mcu_cmd_pkg::op_status) begin
        if (cnt[0]) exp_byte = {1'b0, dac_status, msu_status[6], 5'b00000};
        else exp_byte = {2'b00, msu_status[5:0]};
        check_value("status byte", 64'(spi_data_out), 64'(exp_byte));
      end
    end
    if (grp == mcu_cmd_pkg::grp_addr && t.cmd[1:0] != 2'b01 && t.cmd[1:0] != 2'b10) begin
      exp_addr = t.exp;
    end
    if (t.cmd == mcu_cmd_pkg::op_dspx_rst_addr) begin
      exp_pgm_addr = '0;
      exp_dat_addr = '0;
    end
    if (t.cmd == mcu_cmd_pkg::op_dspx_pgm) begin
      check_value("program RAM write pulses", 64'(pgm_log.size()), 64'd1);
      if (pgm_log.size() > 0) begin
        pgm_word = pgm_log.pop_front();
        check_value("program RAM address", 64'(pgm_word[34:24]), 64'(exp_pgm_addr));
        check_value("program RAM word", 64'(pgm_word[23:0]), 64'({t.p[0], t.p[1], t.p[2]}));
      end
      exp_pgm_addr = exp_pgm_addr + 11'd1;
    end
    if (t.cmd == mcu_cmd_pkg::op_dspx_dat) begin
      check_value("data RAM write pulses", 64'(dat_log.size()), 64'd1);
      if (dat_log.size() > 0) begin
        dat_word = dat_log.pop_front();
        check_value("data RAM address", 64'(dat_word[25:16]), 64'(exp_dat_addr));
        check_value("data RAM word", 64'(dat_word[15:0]), 64'({t.p[0], t.p[1]}));
      end
      exp_dat_addr = exp_dat_addr + 10'd1;
    end
    check_value($sformatf("command %h result", t.cmd), observed_value(t.cmd), 64'(t.exp));
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int i;
    rst = 1'b1;
    spi = '0;
    dac_status = 1'b1;
    msu_status = 7'h5b;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("cfg after reset", cfg, {3'd1, 61'd0});
    check_value("pointers after reset", 64'(ptr), 64'd0);
    check_value("dsp outputs after reset", dspx, 64'd1);
    check_value("requests after reset", 64'({mcu_rrq, mcu_wrq}), 64'd0);
    check_value("response after reset", 64'(spi_data_out), 64'd0);
    for (i = 0; i < num_txn; i++) begin
      run_txn(tbl[i]);
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- dv/mcu_cmd_properties.sv
module mcu_cmd_properties #(
  parameter bit single_pulse = 1'b1
) (
  input logic clk,
  input logic rst,
  input logic pulse_a,
  input logic pulse_b
);

  // request pulses are one cycle wide
  if (single_pulse) begin : g_width
    a_width_a: assert property (
      @(posedge clk) disable iff (rst) pulse_a |=> !pulse_a
    ) else $error("pulse_a high for more than one cycle");

    a_width_b: assert property (
      @(posedge clk) disable iff (rst) pulse_b |=> !pulse_b
    ) else $error("pulse_b high for more than one cycle");
  end

  // the two strobes never overlap
  a_exclusive: assert property (
    @(posedge clk) disable iff (rst) !(pulse_a && pulse_b)
  ) else $error("pulse_a and pulse_b high together");

  // cleared by a reset cycle
  a_reset_low: assert property (
    @(posedge clk) rst |=> (!pulse_a && !pulse_b)
  ) else $error("strobe high after reset");

endmodule

bind mcu_mem_req mcu_cmd_properties #(.single_pulse(1'b1)) u_req_props (
  .clk     (clk),
  .rst     (rst),
  .pulse_a (mcu_rrq),
  .pulse_b (mcu_wrq)
);

bind dspx_loader mcu_cmd_properties #(.single_pulse(1'b0)) u_we_props (
  .clk     (clk),
  .rst     (rst),
  .pulse_a (dspx.pgm_we),
  .pulse_b (dspx.dat_we)
);

//--- hdl/mcu_cmd_top.sv
module mcu_cmd_top #(
  parameter logic [7:0] id_byte = 8'ha5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_cmd_t spi,
  // cartridge memory
  input  logic                  mcu_rq_rdy,
  input  logic [7:0]            mcu_data_in,
  output logic                  mcu_rrq,
  output logic                  mcu_wrq,
  output logic [7:0]            mcu_data_out,
  // status
  input  logic                  dac_status,
  input  logic [6:0]            msu_status,
  output logic [7:0]            spi_data_out,
  output mcu_cmd_pkg::cfg_t     cfg,
  output mcu_cmd_pkg::ptr_t     ptr,
  output mcu_cmd_pkg::dspx_t    dspx
);

  logic [7:0] rd_data;
  logic       rd_valid;
  logic       addr_step;

  cmd_config_regs u_cmd_config_regs (
    .clk (clk),
    .rst (rst),
    .spi (spi),
    .cfg (cfg)
  );

  addr_pointers u_addr_pointers (
    .clk       (clk),
    .rst       (rst),
    .spi       (spi),
    .addr_step (addr_step),
    .ptr       (ptr)
  );

  mcu_mem_req u_mcu_mem_req (
    .clk          (clk),
    .rst          (rst),
    .spi          (spi),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .addr_step    (addr_step)
  );

  spi_response #(
    .id_byte (id_byte)
  ) u_spi_response (
    .clk          (clk),
    .rst          (rst),
    .spi          (spi),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .dac_status   (dac_status),
    .msu_status   (msu_status),
    .spi_data_out (spi_data_out)
  );

  dspx_loader u_dspx_loader (
    .clk  (clk),
    .rst  (rst),
    .spi  (spi),
    .dspx (dspx)
  );

endmodule

//--- hdl/dspx_loader.sv
module dspx_loader (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_cmd_t spi,
  output mcu_cmd_pkg::dspx_t    dspx
);

  always_ff @(posedge clk) begin
    if (rst) begin
      dspx <= '0;
      // hold the coprocessor in reset until loaded
      dspx.reset <= 1'b1;
    end else if (spi.param_ready) begin
      case (spi.cmd.op)
        mcu_cmd_pkg::op_dspx_rst_addr: begin
          if (spi.byte_cnt == 8'd2) begin
            dspx.pgm_addr <= '0;
            dspx.dat_addr <= '0;
          end
        end
        ////////////////////
        // program word, 3 bytes
        ////////////////////
        mcu_cmd_pkg::op_dspx_pgm: begin
          case (spi.byte_cnt)
            8'd2: dspx.pgm_data[23:16] <= spi.param;
            8'd3: dspx.pgm_data[15:8] <= spi.param;
            8'd4: dspx.pgm_data[7:0] <= spi.param;
            8'd5: dspx.pgm_we <= 1'b1;
            8'd6: begin
              dspx.pgm_we <= 1'b0;
              dspx.pgm_addr <= dspx.pgm_addr + 1'b1;
            end
            default: begin
            end
          endcase
        end
        ////////////////////
        // data word, 2 bytes
        ////////////////////
        mcu_cmd_pkg::op_dspx_dat: begin
          case (spi.byte_cnt)
            8'd2: dspx.dat_data[15:8] <= spi.param;
            8'd3: dspx.dat_data[7:0] <= spi.param;
            8'd4: dspx.dat_we <= 1'b1;
            8'd5: begin
              dspx.dat_we <= 1'b0;
              dspx.dat_addr <= dspx.dat_addr + 1'b1;
            end
            default: begin
            end
          endcase
        end
        mcu_cmd_pkg::op_dspx_reset:
          dspx.reset <= spi.param[0];
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hdl/spi_response.sv
module spi_response #(
  parameter logic [7:0] id_byte = 8'ha5
) (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_cmd_t spi,
  input  logic [7:0]            rd_data,
  input  logic                  rd_valid,
  input  logic                  dac_status,
  input  logic [6:0]            msu_status,
  output logic [7:0]            spi_data_out
);

  logic       dac_status_q;
  logic [6:0] msu_status_q;

  // status inputs come from other clock domains
  always_ff @(posedge clk) begin
    if (rst) begin
      dac_status_q <= 1'b0;
      msu_status_q <= 7'h00;
    end else begin
      dac_status_q <= dac_status;
      msu_status_q <= msu_status;
    end
  end

  ////////////////////
  // response byte
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      spi_data_out <= 8'h00;
    end else if (rd_valid) begin
      spi_data_out <= rd_data;
    end else if (spi.cmd_ready | spi.param_ready) begin
      case (spi.cmd.op)
        mcu_cmd_pkg::op_id:
          spi_data_out <= id_byte;
        mcu_cmd_pkg::op_status: begin
          if (spi.byte_cnt[0]) begin
            // buffer status
            spi_data_out <= {1'b0, dac_status_q, msu_status_q[6], 5'b00000};
          end else begin
            // control status
            spi_data_out <= {2'b00, msu_status_q[5:0]};
          end
        end
        mcu_cmd_pkg::op_echo:
          spi_data_out <= spi.param;
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hdl/mcu_mem_req.sv
module mcu_mem_req (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_cmd_t spi,
  input  logic                  mcu_rq_rdy,
  input  logic [7:0]            mcu_data_in,
  output logic                  mcu_rrq,
  output logic                  mcu_wrq,
  output logic [7:0]            mcu_data_out,
  output logic [7:0]            rd_data,
  output logic                  rd_valid,
  output logic                  addr_step
);

  logic [1:0] trig;
  logic [1:0] req_q;
  logic       rdy_q;
  logic       next_addr;
  logic       is_read;
  logic       step_ok;
  logic [mcu_cmd_pkg::byte_cnt_w-1:0] min_cnt;

  assign is_read = spi.cmd.f.grp == mcu_cmd_pkg::grp_read;

  ////////////////////
  // request FSMs
  ////////////////////

  // 0 is read, 1 is write
  assign trig[0] = (spi.cmd_ready | spi.param_ready) && is_read;
  assign trig[1] = spi.param_ready && (spi.cmd.f.grp == mcu_cmd_pkg::grp_write);

  for (genvar i = 0; i < 2; i++) begin : g_rq
    // idle -> rq -> idle, a trigger during rq is dropped
    always_ff @(posedge clk) begin
      if (rst) begin
        req_q[i] <= 1'b0;
      end else begin
        req_q[i] <= trig[i] & ~req_q[i];
      end
    end
  end

  assign mcu_rrq = req_q[0];
  assign mcu_wrq = req_q[1];

  ////////////////////
  // ready edge, data
  ////////////////////

  assign next_addr = mcu_rq_rdy & ~rdy_q;

  // step only for 8x/9x with bit 3, past the address bytes
  assign min_cnt = spi.cmd.op[4] ? mcu_cmd_pkg::byte_cnt_w'(2) : mcu_cmd_pkg::byte_cnt_w'(1);
  assign step_ok = (spi.cmd.op[7:5] == 3'b100) && spi.cmd.op[3] && (spi.byte_cnt >= min_cnt);

  always_ff @(posedge clk) begin
    if (rst) begin
      rdy_q <= 1'b0;
      rd_data <= 8'h00;
      rd_valid <= 1'b0;
      addr_step <= 1'b0;
      mcu_data_out <= 8'h00;
    end else begin
      rdy_q <= mcu_rq_rdy;
      rd_valid <= next_addr & is_read;
      addr_step <= next_addr & step_ok;
      if (next_addr && is_read) begin
        rd_data <= mcu_data_in;
      end
      if (trig[1]) begin
        mcu_data_out <= spi.param;
      end
    end
  end

endmodule

//--- hdl/addr_pointers.sv
module addr_pointers (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_cmd_t spi,
  input  logic                  addr_step,
  output mcu_cmd_pkg::ptr_t     ptr
);

  logic load;

  assign load = spi.param_ready && (spi.cmd.f.grp == mcu_cmd_pkg::grp_addr);

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (load) begin
      case (spi.cmd.f.sub[1:0])
        // dac pointer
        2'b01: begin
          case (spi.byte_cnt)
            8'd2: begin
              ptr.dac_addr[10:8] <= spi.param[2:0];
              ptr.dac_addr[7:0] <= 8'h00;
            end
            8'd3:
              ptr.dac_addr[7:0] <= spi.param;
            default: begin
            end
          endcase
        end
        // msu pointer
        2'b10: begin
          case (spi.byte_cnt)
            8'd2: begin
              ptr.msu_addr[13:8] <= spi.param[5:0];
              ptr.msu_addr[7:0] <= 8'h00;
            end
            8'd3:
              ptr.msu_addr[7:0] <= spi.param;
            default: begin
            end
          endcase
        end
        default: begin
          case (spi.byte_cnt)
            8'd2: begin
              ptr.addr[23:16] <= spi.param;
              ptr.addr[15:0] <= 16'h0000;
            end
            8'd3:
              ptr.addr[15:8] <= spi.param;
            8'd4:
              ptr.addr[7:0] <= spi.param;
            default: begin
            end
          endcase
        end
      endcase
    end else if (addr_step) begin
      // auto increment after memory access
      ptr.addr <= ptr.addr + 1'b1;
    end
  end

endmodule

//--- hdl/cmd_config_regs.sv
module cmd_config_regs (
  input  logic                  clk,
  input  logic                  rst,
  input  mcu_cmd_pkg::spi_cmd_t spi,
  output mcu_cmd_pkg::cfg_t     cfg
);

  // byte lane insert for the 24-bit masks, msb first
  function automatic logic [mcu_cmd_pkg::addr_w-1:0] mask_load(
    input logic [mcu_cmd_pkg::addr_w-1:0]     cur,
    input logic [mcu_cmd_pkg::byte_cnt_w-1:0] cnt,
    input logic [7:0]                         data
  );
    logic [mcu_cmd_pkg::addr_w-1:0] nxt;
    nxt = cur;
    case (cnt)
      8'd2: nxt[23:16] = data;
      8'd3: nxt[15:8]  = data;
      8'd4: nxt[7:0]   = data;
      default: nxt = cur;
    endcase
    return nxt;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg <= '0;
      cfg.mapper <= 3'd1;
    end else if (spi.cmd_ready) begin
      if (spi.cmd.f.grp == mcu_cmd_pkg::grp_mapper) begin
        cfg.mapper <= spi.cmd.f.sub[2:0];
      end
    end else if (spi.param_ready) begin
      case (spi.cmd.f.grp)
        mcu_cmd_pkg::grp_rom_mask:
          cfg.rom_mask <= mask_load(cfg.rom_mask, spi.byte_cnt, spi.param);
        mcu_cmd_pkg::grp_sram_mask:
          cfg.sram_mask <= mask_load(cfg.sram_mask, spi.byte_cnt, spi.param);
        default: begin
        end
      endcase
      case (spi.cmd.op)
        mcu_cmd_pkg::op_dac_props: begin
          cfg.dac_vol <= spi.param[2:0];
          cfg.dac_pal <= spi.param[7];
        end
        mcu_cmd_pkg::op_features:
          cfg.features <= spi.param;
        mcu_cmd_pkg::op_region:
          cfg.region <= spi.param[0];
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hdl/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int addr_w     = 24;
  localparam int dac_addr_w = 11;
  localparam int msu_addr_w = 14;
  localparam int pgm_addr_w = 11;
  localparam int dat_addr_w = 10;
  localparam int byte_cnt_w = 8;

  ////////////////////
  // opcodes
  ////////////////////

  // command groups, high nibble
  localparam logic [3:0] grp_addr      = 4'h0;
  localparam logic [3:0] grp_rom_mask  = 4'h1;
  localparam logic [3:0] grp_sram_mask = 4'h2;
  localparam logic [3:0] grp_mapper    = 4'h3;
  localparam logic [3:0] grp_read      = 4'h8;
  localparam logic [3:0] grp_write     = 4'h9;

  // full opcodes
  localparam logic [7:0] op_dspx_rst_addr = 8'he8;
  localparam logic [7:0] op_dspx_pgm      = 8'he9;
  localparam logic [7:0] op_dspx_dat      = 8'hea;
  localparam logic [7:0] op_dspx_reset    = 8'heb;
  localparam logic [7:0] op_dac_props     = 8'hec;
  localparam logic [7:0] op_features      = 8'hed;
  localparam logic [7:0] op_region        = 8'hee;
  localparam logic [7:0] op_id            = 8'hf0;
  localparam logic [7:0] op_status        = 8'hf1;
  localparam logic [7:0] op_echo          = 8'hff;

  ////////////////////
  // bundles
  ////////////////////

  typedef struct packed {
    logic [3:0] grp;
    logic [3:0] sub;
  } cmd_fields_t;

  // command byte, decoded as full opcode or as group/sub nibbles
  typedef union packed {
    logic [7:0]  op;
    cmd_fields_t f;
  } cmd_word_u;

  typedef struct packed {
    logic                  cmd_ready;
    logic                  param_ready;
    cmd_word_u             cmd;
    logic [7:0]            param;
    logic [byte_cnt_w-1:0] byte_cnt;
  } spi_cmd_t;

  typedef struct packed {
    logic [2:0]        mapper;
    logic [addr_w-1:0] rom_mask;
    logic [addr_w-1:0] sram_mask;
    logic [7:0]        features;
    logic              region;
    logic [2:0]        dac_vol;
    logic              dac_pal;
  } cfg_t;

  typedef struct packed {
    logic [addr_w-1:0]     addr;
    logic [dac_addr_w-1:0] dac_addr;
    logic [msu_addr_w-1:0] msu_addr;
  } ptr_t;

  typedef struct packed {
    logic [23:0]           pgm_data;
    logic [pgm_addr_w-1:0] pgm_addr;
    logic                  pgm_we;
    logic [15:0]           dat_data;
    logic [dat_addr_w-1:0] dat_addr;
    logic                  dat_we;
    logic                  reset;
  } dspx_t;

endpackage
